// File: Bender.yml
package:
  name: load_unit

export_include_dirs:
  - rtl

sources:
  - rtl/load_unit_pkg.sv
  - rtl/load_pending.sv
  - rtl/load_result.sv
  - rtl/load_ctrl.sv
  - rtl/load_unit.sv
  - target: test
    files:
      - testbench/tb_mem_env.sv
      - testbench/tb_load_unit.sv

// File: rtl/load_ctrl.sv
// --------------------
// load-control FSM, one load in its index phase at a time
// the cache must answer an unkilled tag with rvalid in the same cycle
// the MMU answers dtlb_hit_i and paddr_i in the cycle of the request
// a flush kills the tag in flight and any load just granted
// --------------------

`timescale 1ns/1ns
`default_nettype none

`include "load_unit_defs.svh"

module load_ctrl (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      flush_i,
    input  wire logic                      valid_i,
    input  wire load_unit_pkg::load_req_t  load_req_i,
    input  wire logic                      dtlb_hit_i,
    input  wire logic [`LU_PADDR_WIDTH-1:0] paddr_i,
    input  wire logic                      page_offset_match_i,
    input  wire load_unit_pkg::dcache_rsp_t dcache_rsp_i,
    output logic                           pop_ld_o,
    output logic                           translation_req_o,
    output load_unit_pkg::dcache_req_t     dcache_req_o,
    output logic                           valid_o
);

    load_unit_pkg::lu_state_e state_d, state_q;

    logic                     accept;
    logic                     data_req;
    logic                     tag_valid;
    logic                     kill_req;
    logic [1:0]               data_size;
    logic [`LU_TAG_WIDTH-1:0] tag_q;

    // a new load may start its index phase from IDLE or alongside a tag cycle
    assign accept = valid_i &&
                    (state_q == load_unit_pkg::IDLE || state_q == load_unit_pkg::SEND_TAG);

    // --------------------
    // next state
    // --------------------
    always_comb begin : p_fsm
        state_d           = state_q;
        translation_req_o = 1'b0;
        data_req          = 1'b0;
        tag_valid         = 1'b0;
        kill_req          = 1'b0;
        pop_ld_o          = 1'b0;

        case (state_q)
            // the tag of the popped load goes out, then back to idle unless a new load starts
            load_unit_pkg::SEND_TAG: begin
                tag_valid = 1'b1;
                state_d   = load_unit_pkg::IDLE;
            end
            // hold off the cache until no older store shares the page offset
            load_unit_pkg::WAIT_PAGE_OFFSET: begin
                if (!page_offset_match_i) begin
                    state_d = load_unit_pkg::WAIT_GNT;
                end
            end
            // translation and index stay up until the cache grants
            load_unit_pkg::WAIT_GNT: begin
                translation_req_o = 1'b1;
                data_req          = 1'b1;
                if (dcache_rsp_i.data_gnt) begin
                    if (dtlb_hit_i) begin
                        state_d  = load_unit_pkg::SEND_TAG;
                        pop_ld_o = 1'b1;
                    end else begin
                        state_d = load_unit_pkg::ABORT_TRANSACTION;
                    end
                end
            end
            // a TLB miss at grant frees the cache so the table walk can use it
            load_unit_pkg::ABORT_TRANSACTION: begin
                kill_req  = 1'b1;
                tag_valid = 1'b1;
                state_d   = load_unit_pkg::WAIT_TRANSLATION;
            end
            // keep asking the MMU; once it hits, the index is sent again
            load_unit_pkg::WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = load_unit_pkg::WAIT_GNT;
                end
            end
            // kill whatever index was granted before the flush
            load_unit_pkg::WAIT_FLUSH: begin
                kill_req  = 1'b1;
                tag_valid = 1'b1;
                state_d   = load_unit_pkg::IDLE;
            end
            default: begin
                state_d = state_q;
            end
        endcase

        // start of a new load, translation is asked for even before the offset check
        if (accept) begin
            translation_req_o = 1'b1;
            if (page_offset_match_i) begin
                state_d = load_unit_pkg::WAIT_PAGE_OFFSET;
            end else begin
                data_req = 1'b1;
                if (!dcache_rsp_i.data_gnt) begin
                    state_d = load_unit_pkg::WAIT_GNT;
                end else if (dtlb_hit_i) begin
                    state_d  = load_unit_pkg::SEND_TAG;
                    pop_ld_o = 1'b1;
                end else begin
                    state_d = load_unit_pkg::ABORT_TRANSACTION;
                end
            end
        end

        // a flush during the tag cycle kills that tag too, so nothing retires from it
        if (flush_i) begin
            state_d = load_unit_pkg::WAIT_FLUSH;
            if (state_q == load_unit_pkg::SEND_TAG) begin
                kill_req = 1'b1;
            end
        end
    end

    // access size as log2 of the byte count
    always_comb begin : p_size
        case (load_req_i.op)
            load_unit_pkg::LW, load_unit_pkg::LWU: data_size = 2'b10;
            load_unit_pkg::LH, load_unit_pkg::LHU: data_size = 2'b01;
            load_unit_pkg::LB, load_unit_pkg::LBU: data_size = 2'b00;
            default:                               data_size = 2'b11;
        endcase
    end

    // retire only from a tag cycle the cache was allowed to answer
    assign valid_o = dcache_rsp_i.data_rvalid && state_q == load_unit_pkg::SEND_TAG && !kill_req;

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= load_unit_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the tag is kept from the pop cycle, since the MMU may already serve the next load
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_tag
        if (!rst_ni) begin
            tag_q <= '0;
        end else if (pop_ld_o) begin
            tag_q <= paddr_i[`LU_TAG_WIDTH+`LU_INDEX_WIDTH-1:`LU_INDEX_WIDTH];
        end
    end

    assign dcache_req_o.data_req      = data_req;
    assign dcache_req_o.address_index = load_req_i.vaddr[`LU_INDEX_WIDTH-1:0];
    assign dcache_req_o.address_tag   = tag_q;
    assign dcache_req_o.tag_valid     = tag_valid;
    assign dcache_req_o.kill_req      = kill_req;
    assign dcache_req_o.data_size     = data_size;

endmodule

`default_nettype wire

// File: rtl/load_pending.sv
// --------------------
// holds the load between pop and its tag cycle
// the sign byte index assumes naturally aligned addresses
// --------------------

`timescale 1ns/1ns
`default_nettype none

module load_pending (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire logic                     pop_i,
    input  wire load_unit_pkg::load_req_t load_req_i,
    output load_unit_pkg::load_meta_t     meta_o
);

    load_unit_pkg::load_meta_t meta_d, meta_q;

    // --------------------
    // decode at capture
    // --------------------

    // the sign selection is decoded here so the result path only indexes a bit
    always_comb begin : p_decode
        meta_d.trans_id  = load_req_i.trans_id;
        meta_d.offset    = load_req_i.vaddr[2:0];
        meta_d.op        = load_req_i.op;
        meta_d.is_signed = load_req_i.op inside {load_unit_pkg::LW,
                                                 load_unit_pkg::LH,
                                                 load_unit_pkg::LB};

        // the sign sits in the most significant byte of the accessed field
        case (load_req_i.op)
            load_unit_pkg::LW, load_unit_pkg::LWU: begin
                meta_d.sign_idx = load_req_i.vaddr[2:0] + 3'd3;
            end
            load_unit_pkg::LH, load_unit_pkg::LHU: begin
                meta_d.sign_idx = load_req_i.vaddr[2:0] + 3'd1;
            end
            default: begin
                meta_d.sign_idx = load_req_i.vaddr[2:0];
            end
        endcase
    end

    // --------------------
    // capture register
    // --------------------

    // only a pop loads new data, so the meta stays stable through the tag cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_meta
        if (!rst_ni) begin
            meta_q <= '0;
        end else if (pop_i) begin
            meta_q <= meta_d;
        end
    end

    assign meta_o = meta_q;

endmodule

`default_nettype wire

// File: rtl/load_result.sv
// --------------------
// aligns the cache word and extends it by operator
// purely combinational, valid in the tag cycle only
// --------------------

`timescale 1ns/1ns
`default_nettype none

`include "load_unit_defs.svh"

module load_result (
    input  wire load_unit_pkg::load_meta_t       meta_i,
    input  wire logic [`LU_DATA_WIDTH-1:0]       rdata_i,
    output logic [`LU_TRANS_ID_WIDTH-1:0]        trans_id_o,
    output logic [`LU_DATA_WIDTH-1:0]            result_o
);

    logic [`LU_DATA_WIDTH-1:0] shifted;
    logic [7:0]                sign_bits;
    logic                      sign_bit;

    assign trans_id_o = meta_i.trans_id;

    // --------------------
    // alignment
    // --------------------

    // move the addressed byte down to lane zero
    assign shifted = rdata_i >> {meta_i.offset, 3'b000};

    // the top bit of every byte lane, taken from the unshifted word
    always_comb begin : p_sign_bits
        for (int i = 0; i < 8; i++) begin
            sign_bits[i] = rdata_i[8*i+7];
        end
    end

    // this select runs beside the shifter rather than after it
    // unsigned loads pull the fill to zero
    assign sign_bit = meta_i.is_signed & sign_bits[meta_i.sign_idx];

    // --------------------
    // extension
    // --------------------
    always_comb begin : p_extend
        case (meta_i.op)
            load_unit_pkg::LW, load_unit_pkg::LWU: begin
                result_o = {{32{sign_bit}}, shifted[31:0]};
            end
            load_unit_pkg::LH, load_unit_pkg::LHU: begin
                result_o = {{48{sign_bit}}, shifted[15:0]};
            end
            load_unit_pkg::LB, load_unit_pkg::LBU: begin
                result_o = {{56{sign_bit}}, shifted[7:0]};
            end
            // a doubleword is aligned at offset zero, so it passes through
            default: begin
                result_o = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/load_unit.sv
// --------------------
// load unit for a 64-bit in-order core
// one load in its index phase and one in its tag phase at most
// valid_i and load_req_i must be held until pop_ld_o
// results carry no back-pressure, valid_o is a one-cycle strobe
// --------------------

`timescale 1ns/1ns
`default_nettype none

`include "load_unit_defs.svh"

module load_unit (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire logic                       flush_i,
    // issue side
    input  wire logic                       valid_i,
    input  wire load_unit_pkg::load_req_t   load_req_i,
    output logic                            pop_ld_o,
    // MMU
    output logic                            translation_req_o,
    input  wire logic                       dtlb_hit_i,
    input  wire logic [`LU_PADDR_WIDTH-1:0] paddr_i,
    // store offset checker
    input  wire logic                       page_offset_match_i,
    // data cache
    output load_unit_pkg::dcache_req_t      dcache_req_o,
    input  wire load_unit_pkg::dcache_rsp_t dcache_rsp_i,
    // retirement
    output logic                            valid_o,
    output logic [`LU_TRANS_ID_WIDTH-1:0]   trans_id_o,
    output logic [`LU_DATA_WIDTH-1:0]       result_o
);

    logic                      pop;
    load_unit_pkg::load_meta_t meta;

    // --------------------
    // control
    // --------------------
    load_ctrl i_load_ctrl (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .valid_i             (valid_i),
        .load_req_i          (load_req_i),
        .dtlb_hit_i          (dtlb_hit_i),
        .paddr_i             (paddr_i),
        .page_offset_match_i (page_offset_match_i),
        .dcache_rsp_i        (dcache_rsp_i),
        .pop_ld_o            (pop),
        .translation_req_o   (translation_req_o),
        .dcache_req_o        (dcache_req_o),
        .valid_o             (valid_o)
    );

    // the pop strobe goes to the issue queue and to the capture register alike
    assign pop_ld_o = pop;

    // --------------------
    // datapath
    // --------------------
    load_pending i_load_pending (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .pop_i      (pop),
        .load_req_i (load_req_i),
        .meta_o     (meta)
    );

    load_result i_load_result (
        .meta_i     (meta),
        .rdata_i    (dcache_rsp_i.data_rdata),
        .trans_id_o (trans_id_o),
        .result_o   (result_o)
    );

endmodule

`default_nettype wire

// File: rtl/load_unit_defs.svh
// --------------------
// width parameters of the load unit
// the tag and index together must cover the physical address
// the data width is fixed at 64 bits by the byte-lane logic
// --------------------

`ifndef LOAD_UNIT_DEFS_SVH
`define LOAD_UNIT_DEFS_SVH

// width of one cache word and of the retired result
`define LU_DATA_WIDTH 64

// cache index, taken straight from the untranslated page offset
`define LU_INDEX_WIDTH 12

// cache tag, the physical address bits above the index
`define LU_TAG_WIDTH 44

// physical address as delivered by the MMU
`define LU_PADDR_WIDTH 56

// scoreboard transaction ID
`define LU_TRANS_ID_WIDTH 3

`endif

// File: rtl/load_unit_pkg.sv
// --------------------
// types shared by the load unit and its blocks
// struct widths follow the macros in the defs header
// only integer loads are covered, no floating point
// --------------------

`default_nettype none

`include "load_unit_defs.svh"

package load_unit_pkg;

    // --------------------
    // enums
    // --------------------

    // load operators, the encoding is local to this unit
    typedef enum logic [2:0] {
        LD  = 3'd0,
        LW  = 3'd1,
        LWU = 3'd2,
        LH  = 3'd3,
        LHU = 3'd4,
        LB  = 3'd5,
        LBU = 3'd6
    } load_op_e;

    // states of the load-control FSM
    typedef enum logic [2:0] {
        IDLE              = 3'd0,
        WAIT_GNT          = 3'd1,
        SEND_TAG          = 3'd2,
        WAIT_PAGE_OFFSET  = 3'd3,
        ABORT_TRANSACTION = 3'd4,
        WAIT_TRANSLATION  = 3'd5,
        WAIT_FLUSH        = 3'd6
    } lu_state_e;

    // --------------------
    // structs
    // --------------------

    // request from the issue queue, held until it is popped
    typedef struct packed {
        logic [`LU_TRANS_ID_WIDTH-1:0] trans_id;
        logic [63:0]                   vaddr;
        load_op_e                      op;
    } load_req_t;

    // request toward the data cache
    // data_size is log2 of the access size in bytes
    typedef struct packed {
        logic                       data_req;
        logic [`LU_INDEX_WIDTH-1:0] address_index;
        logic [`LU_TAG_WIDTH-1:0]   address_tag;
        logic                       tag_valid;
        logic                       kill_req;
        logic [1:0]                 data_size;
    } dcache_req_t;

    // response from the data cache
    typedef struct packed {
        logic                      data_gnt;
        logic                      data_rvalid;
        logic [`LU_DATA_WIDTH-1:0] data_rdata;
    } dcache_rsp_t;

    // the load whose tag is on its way, with sign selection already decoded
    typedef struct packed {
        logic [`LU_TRANS_ID_WIDTH-1:0] trans_id;
        logic [2:0]                    offset;
        load_op_e                      op;
        logic [2:0]                    sign_idx;
        logic                          is_signed;
    } load_meta_t;

endpackage

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/load_unit_pkg.sv
rtl/load_pending.sv
rtl/load_result.sv
rtl/load_ctrl.sv
rtl/load_unit.sv
testbench/tb_mem_env.sv
testbench/tb_load_unit.sv

// File: testbench/tb_load_unit.sv
// --------------------
// random regression for the load unit
// the cache, MMU and store checker are modeled by tb_mem_env
// inputs change on the falling edge, outputs are sampled on the rising edge
// a load flushed before its pop stays held and is accepted again
// --------------------

`timescale 1ns/1ns
`default_nettype none

`include "load_unit_defs.svh"

module tb_load_unit;

    localparam int NUM_LOADS      = 400;
    localparam int TIMEOUT_CYCLES = NUM_LOADS * 20;

    // coarse view of where the unit stands, rebuilt from what is seen on its ports
    localparam int PH_IDLE   = 0;
    localparam int PH_OFFSET = 1;
    localparam int PH_INDEX  = 2;
    localparam int PH_ABORT  = 3;
    localparam int PH_RETRY  = 4;
    localparam int PH_FLUSH  = 5;

    // a popped load as the model expects it in its tag cycle
    typedef struct packed {
        load_unit_pkg::load_req_t req;
        logic [`LU_TAG_WIDTH-1:0] tag;
        logic                     flushed;
    } popped_t;

    logic                                  clk_i;
    logic                                  rst_ni;
    logic                                  flush_i;
    logic                                  valid_i;
    load_unit_pkg::load_req_t              load_req_i;
    logic                                  pop_ld_o;
    logic                                  translation_req_o;
    logic                                  dtlb_hit_i;
    logic [`LU_PADDR_WIDTH-1:0]            paddr_i;
    logic                                  page_offset_match_i;
    load_unit_pkg::dcache_req_t            dcache_req;
    load_unit_pkg::dcache_rsp_t            dcache_rsp;
    logic                                  valid_o;
    logic [`LU_TRANS_ID_WIDTH-1:0]         trans_id_o;
    logic [`LU_DATA_WIDTH-1:0]             result_o;

    popped_t inflight[$];
    logic  seen_valid = 1'b0;
    int    phase = PH_IDLE;
    int    retired = 0;
    int    killed = 0;
    int    cycles = 0;
    int    total_err = 0;
    int    checks [6] = '{default: 0};
    int    errors [6] = '{default: 0};
    string names  [6] = '{"retire data", "offset stall", "grant wait",
                          "tlb miss", "flush", "reset state"};

    load_unit i_load_unit (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .valid_i             (valid_i),
        .load_req_i          (load_req_i),
        .pop_ld_o            (pop_ld_o),
        .translation_req_o   (translation_req_o),
        .dtlb_hit_i          (dtlb_hit_i),
        .paddr_i             (paddr_i),
        .page_offset_match_i (page_offset_match_i),
        .dcache_req_o        (dcache_req),
        .dcache_rsp_i        (dcache_rsp),
        .valid_o             (valid_o),
        .trans_id_o          (trans_id_o),
        .result_o            (result_o)
    );

    // flushes start only once loads are flowing
    tb_mem_env i_mem_env (
        .clk_i               (clk_i),
        .active_i            (seen_valid),
        .dcache_req_i        (dcache_req),
        .dcache_rsp_o        (dcache_rsp),
        .dtlb_hit_o          (dtlb_hit_i),
        .paddr_o             (paddr_i),
        .page_offset_match_o (page_offset_match_i),
        .flush_o             (flush_i)
    );

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    task automatic check(input int idx, input logic ok, input string msg);
        checks[idx]++;
        assert (ok) else begin
            $display("%s", msg);
            errors[idx]++;
        end
    endtask

    // number of bytes that an operator reads
    function automatic int access_bytes(input load_unit_pkg::load_op_e op);
        case (op)
            load_unit_pkg::LW, load_unit_pkg::LWU: return 4;
            load_unit_pkg::LH, load_unit_pkg::LHU: return 2;
            load_unit_pkg::LB, load_unit_pkg::LBU: return 1;
            default:                               return 8;
        endcase
    endfunction

    // the addressed field moved to bit zero and widened as the operator asks
    function automatic logic [`LU_DATA_WIDTH-1:0] expected_result(
        input load_unit_pkg::load_op_e  op,
        input logic [2:0]               offset,
        input logic [`LU_DATA_WIDTH-1:0] word
    );
        logic [`LU_DATA_WIDTH-1:0] field;
        field = word >> (8 * offset);
        case (op)
            load_unit_pkg::LW:  return 64'($signed(field[31:0]));
            load_unit_pkg::LWU: return 64'(field[31:0]);
            load_unit_pkg::LH:  return 64'($signed(field[15:0]));
            load_unit_pkg::LHU: return 64'(field[15:0]);
            load_unit_pkg::LB:  return 64'($signed(field[7:0]));
            load_unit_pkg::LBU: return 64'(field[7:0]);
            default:            return field;
        endcase
    endfunction

    // --------------------
    // monitor and model
    // --------------------
    always @(posedge clk_i) begin : p_monitor
        popped_t                   ent;
        popped_t                   nxt;
        logic [`LU_DATA_WIDTH-1:0] exp;
        logic                      exp_kill;
        logic [1:0]                exp_size;
        if (!rst_ni) begin
            phase = PH_IDLE;
        end else begin
            // before any load is offered every control output must stay quiet
            if (!seen_valid && !valid_i) begin
                check(5, !(pop_ld_o | valid_o | translation_req_o | dcache_req.data_req |
                           dcache_req.tag_valid | dcache_req.kill_req),
                      "a control output was raised before the first load");
            end
            seen_valid = seen_valid | valid_i;

            // a load popped last cycle has its tag cycle now, it retires unless killed
            if (inflight.size() != 0) begin
                ent = inflight.pop_front();
                // a flush in the pop cycle or in the tag cycle itself kills the tag
                exp_kill = ent.flushed | flush_i;
                check(4, dcache_req.kill_req == exp_kill,
                      $sformatf("Mismatch kill_req: got %h expected %h",
                                dcache_req.kill_req, exp_kill));
                if (exp_kill) begin
                    killed++;
                    check(4, !valid_o, "valid_o was raised from a killed tag");
                end else begin
                    check(0, valid_o, "an unkilled tag cycle did not retire its load");
                    check(0, dcache_req.address_tag == ent.tag,
                          $sformatf("Mismatch address_tag: got %h expected %h",
                                    dcache_req.address_tag, ent.tag));
                    exp = expected_result(ent.req.op, ent.req.vaddr[2:0],
                                          dcache_rsp.data_rdata);
                    check(0, trans_id_o == ent.req.trans_id,
                          $sformatf("Mismatch trans_id_o: got %h expected %h",
                                    trans_id_o, ent.req.trans_id));
                    check(0, result_o == exp,
                          $sformatf("Mismatch result_o: got %h expected %h", result_o, exp));
                    retired++;
                end
            end else begin
                check(0, !valid_o, "valid_o was raised with no load outstanding");
            end
            if (pop_ld_o) begin
                nxt.req     = load_req_i;
                nxt.tag     = paddr_i[`LU_TAG_WIDTH+`LU_INDEX_WIDTH-1:`LU_INDEX_WIDTH];
                nxt.flushed = flush_i;
                inflight.push_back(nxt);
            end

            case (phase)
                PH_IDLE: begin
                    if (valid_i && page_offset_match_i) begin
                        check(1, !dcache_req.data_req && !pop_ld_o,
                              "the cache was requested while the page offset matched");
                    end
                end
                PH_OFFSET: check(1, !dcache_req.data_req && !pop_ld_o,
                                 "the cache was requested during the page offset stall");
                PH_INDEX: check(2, dcache_req.data_req && translation_req_o,
                                "a request was dropped while the grant was withheld");
                PH_ABORT: check(3, dcache_req.kill_req && dcache_req.tag_valid && !valid_o,
                                "a TLB miss at grant did not kill the cache request");
                PH_RETRY: check(3, !dcache_req.data_req && !pop_ld_o,
                                "the cache was requested before the translation hit");
                default: check(4, dcache_req.kill_req && dcache_req.tag_valid && !valid_o,
                               "the cycle after a flush did not kill the tag");
            endcase
            if (pop_ld_o) begin
                check(2, dcache_rsp.data_gnt && dtlb_hit_i,
                      "pop_ld_o fired without both a grant and a TLB hit");
            end
            if (dcache_req.data_req) begin
                check(2, dcache_req.address_index == load_req_i.vaddr[`LU_INDEX_WIDTH-1:0],
                      $sformatf("Mismatch address_index: got %h expected %h",
                                dcache_req.address_index,
                                load_req_i.vaddr[`LU_INDEX_WIDTH-1:0]));
                // the size field is log2 of the bytes read
                exp_size = 2'($clog2(access_bytes(load_req_i.op)));
                check(2, dcache_req.data_size == exp_size,
                      $sformatf("Mismatch data_size: got %h expected %h",
                                dcache_req.data_size, exp_size));
            end
            if (flush_i) begin
                check(4, !valid_o, "valid_o was raised in a flush cycle");
            end

            // advance the port-level view by the rules of the handshake
            if (flush_i) begin
                phase = PH_FLUSH;
            end else begin
                case (phase)
                    PH_IDLE: begin
                        if (valid_i && page_offset_match_i) begin
                            phase = PH_OFFSET;
                        end else if (valid_i && !dcache_rsp.data_gnt) begin
                            phase = PH_INDEX;
                        end else if (valid_i && !dtlb_hit_i) begin
                            phase = PH_ABORT;
                        end
                    end
                    PH_OFFSET: phase = page_offset_match_i ? PH_OFFSET : PH_INDEX;
                    PH_INDEX: begin
                        if (dcache_rsp.data_gnt) begin
                            phase = dtlb_hit_i ? PH_IDLE : PH_ABORT;
                        end
                    end
                    PH_ABORT: phase = PH_RETRY;
                    PH_RETRY: phase = dtlb_hit_i ? PH_INDEX : PH_RETRY;
                    default:  phase = PH_IDLE;
                endcase
            end
        end
    end

    // --------------------
    // stimulus and report
    // --------------------
    initial begin : p_stimulus
        load_unit_pkg::load_req_t req;
        logic [2:0]               off;
        void'($urandom(32'hed24));
        rst_ni     = 1'b0;
        valid_i    = 1'b0;
        load_req_i = '0;
        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;
        repeat (2) @(negedge clk_i);

        for (int n = 0; n < NUM_LOADS; n++) begin
            req.op = load_unit_pkg::load_op_e'($urandom_range(6));
            off    = 3'($urandom_range(7));
            // offsets are kept naturally aligned for the access size
            case (req.op)
                load_unit_pkg::LD:                     off = 3'b000;
                load_unit_pkg::LW, load_unit_pkg::LWU: off = off & 3'b100;
                load_unit_pkg::LH, load_unit_pkg::LHU: off = off & 3'b110;
                default:                               off = off;
            endcase
            req.vaddr      = {$urandom, $urandom};
            req.vaddr[2:0] = off;
            req.trans_id   = 3'($urandom);
            // now and then an idle cycle, otherwise loads follow back to back
            if ($urandom_range(3) == 0) begin
                valid_i = 1'b0;
                @(negedge clk_i);
            end
            valid_i    = 1'b1;
            load_req_i = req;
            @(posedge clk_i);
            while (!pop_ld_o) @(posedge clk_i);
            @(negedge clk_i);
        end
        valid_i = 1'b0;
        repeat (4) @(negedge clk_i);

        check(0, inflight.size() == 0 && retired + killed == NUM_LOADS,
              "loads were lost or retired more than once");
        for (int b = 0; b < 6; b++) begin
            $display("%s: %0d checks, %0d errors", names[b], checks[b], errors[b]);
            total_err += errors[b];
        end
        $display("loads %0d, retired %0d, killed %0d, errors %0d",
                 NUM_LOADS, retired, killed, total_err);
        if (total_err == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : p_timeout
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout, the loads did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_mem_env.sv
// --------------------
// random data cache, MMU and store-offset checker
// an unkilled tag is answered with rvalid in the same cycle
// all other outputs change on the falling edge only
// --------------------

`timescale 1ns/1ns
`default_nettype none

`include "load_unit_defs.svh"

module tb_mem_env (
    input  wire logic                       clk_i,
    input  wire logic                       active_i,
    input  wire load_unit_pkg::dcache_req_t dcache_req_i,
    output load_unit_pkg::dcache_rsp_t      dcache_rsp_o,
    output logic                            dtlb_hit_o,
    output logic [`LU_PADDR_WIDTH-1:0]      paddr_o,
    output logic                            page_offset_match_o,
    output logic                            flush_o
);

    logic                      gnt;
    logic [`LU_DATA_WIDTH-1:0] rdata;

    initial begin
        gnt                 = 1'b0;
        rdata               = '0;
        dtlb_hit_o          = 1'b0;
        paddr_o             = '0;
        page_offset_match_o = 1'b0;
        flush_o             = 1'b0;
    end

    // grants come with a random delay, misses and offset matches now and then
    always @(negedge clk_i) begin : p_drive
        gnt                 = ($urandom_range(99) < 60);
        dtlb_hit_o          = ($urandom_range(99) < 85);
        page_offset_match_o = ($urandom_range(99) < 15);
        paddr_o             = 56'({$urandom, $urandom});
        rdata               = {$urandom, $urandom};
        // flushes are rare and held off until the first load
        flush_o             = active_i && ($urandom_range(199) == 0);
    end

    assign dcache_rsp_o.data_gnt    = gnt;
    assign dcache_rsp_o.data_rvalid = dcache_req_i.tag_valid && !dcache_req_i.kill_req;
    assign dcache_rsp_o.data_rdata  = rdata;

endmodule

`default_nettype wire
